// ==== source/lsu_pkg.sv ====
package lsu_pkg;

   // ----------------------------------------
   // widths
   // ----------------------------------------

   // core address and data path
   localparam int addr_w = 32;
   localparam int word_w = 32;

   // biu beat width and its byte lanes
   localparam int bus_w = 64;
   localparam int bus_bytes = bus_w / 8;

   // byte lanes in one core word
   localparam int word_bytes = word_w / 8;

   // operation code width from the core
   localparam int op_w = 4;

   // ----------------------------------------
   // basic vector types
   // ----------------------------------------

   typedef logic [addr_w-1:0] addr_t;
   typedef logic [word_w-1:0] word_t;
   typedef logic [bus_w-1:0] bus_t;
   typedef logic [bus_bytes-1:0] strb_t;

   // byte offset inside one bus beat
   typedef logic [$clog2(bus_bytes)-1:0] off_t;

   // operations issued by the core
   typedef enum logic [op_w-1:0] {
      op_nop   = 4'd0,
      op_ld_b  = 4'd1,
      op_ld_bu = 4'd2,
      op_ld_h  = 4'd3,
      op_ld_hu = 4'd4,
      op_ld_w  = 4'd5,
      op_st_b  = 4'd6,
      op_st_h  = 4'd7,
      op_st_w  = 4'd8
   } lsu_op_e;

   // load extraction mode carried into ls3
   typedef enum logic [2:0] {
      lk_b  = 3'd0,
      lk_bu = 3'd1,
      lk_h  = 3'd2,
      lk_hu = 3'd3,
      lk_w  = 3'd4
   } load_kind_e;

   // write request payload, 104 bits
   // address sits on top, strobe in the low byte
   typedef struct packed {
      addr_t addr;
      bus_t  data;
      strb_t strb;
   } wr_payload_t;

endpackage

// ==== source/lsu_ls1_stage.sv ====
`timescale 1ns/1ns

module lsu_ls1_stage (
   input  logic                clk,
   input  logic                reset,

   // core issue, single cycle pulse
   input  logic                ecl_lsu_valid_e,
   input  lsu_pkg::lsu_op_e    ecl_lsu_op_e,
   input  lsu_pkg::addr_t      ecl_lsu_base_e,
   input  lsu_pkg::addr_t      ecl_lsu_offset_e,
   input  lsu_pkg::word_t      ecl_lsu_wdata_e,

   // alignment fault back to the core
   output logic                lsu_ecl_except_ale_ls1,
   output lsu_pkg::addr_t      lsu_ecl_except_badv_ls1,

   // ls2 stage registers
   output logic                valid_ls2,
   output logic                load_ls2,
   output logic                store_ls2,
   output lsu_pkg::addr_t      bus_addr_ls2,
   output lsu_pkg::off_t       off_ls2,
   output lsu_pkg::load_kind_e kind_ls2,
   output lsu_pkg::bus_t       wr_data_ls2,
   output lsu_pkg::strb_t      wr_strb_ls2
);

   import lsu_pkg::*;

   addr_t                 addr_ls1;
   logic                  load_ls1;
   logic                  store_ls1;
   logic                  size_b_ls1;
   logic                  size_h_ls1;
   logic                  size_w_ls1;
   logic                  ale_raw_ls1;
   load_kind_e            kind_ls1;
   word_t                 word_data_ls1;
   logic [word_bytes-1:0] word_strb_ls1;
   bus_t                  wr_data_ls1;
   strb_t                 wr_strb_ls1;

   // ----------------------------------------
   // address and decode
   // ----------------------------------------

   // effective address
   assign addr_ls1 = ecl_lsu_base_e + ecl_lsu_offset_e;

   assign load_ls1  = ecl_lsu_op_e inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
   assign store_ls1 = ecl_lsu_op_e inside {op_st_b, op_st_h, op_st_w};

   // access size, shared by loads and stores
   assign size_b_ls1 = ecl_lsu_op_e inside {op_ld_b, op_ld_bu, op_st_b};
   assign size_h_ls1 = ecl_lsu_op_e inside {op_ld_h, op_ld_hu, op_st_h};
   assign size_w_ls1 = ecl_lsu_op_e inside {op_ld_w, op_st_w};

   // extraction mode for the returned beat
   always_comb begin
      case (ecl_lsu_op_e)
         op_ld_b:  kind_ls1 = lk_b;
         op_ld_bu: kind_ls1 = lk_bu;
         op_ld_h:  kind_ls1 = lk_h;
         op_ld_hu: kind_ls1 = lk_hu;
         default:  kind_ls1 = lk_w;
      endcase
   end

   // ----------------------------------------
   // alignment check
   // ----------------------------------------

   // byte accesses can never fault
   assign ale_raw_ls1 = (size_h_ls1 & addr_ls1[0]) |
                        (size_w_ls1 & (|addr_ls1[1:0]));

   assign lsu_ecl_except_ale_ls1  = ecl_lsu_valid_e & ale_raw_ls1;
   assign lsu_ecl_except_badv_ls1 = addr_ls1;

   // ----------------------------------------
   // store lane placement
   // ----------------------------------------

   // replicate across the word so every lane sees the data
   always_comb begin
      word_data_ls1 = ecl_lsu_wdata_e;
      word_strb_ls1 = '1;
      if (size_b_ls1) begin
         word_data_ls1 = {4{ecl_lsu_wdata_e[7:0]}};
         word_strb_ls1 = word_bytes'(1) << addr_ls1[1:0];
      end else if (size_h_ls1) begin
         word_data_ls1 = {2{ecl_lsu_wdata_e[15:0]}};
         word_strb_ls1 = word_bytes'(3) << addr_ls1[1:0];
      end
   end

   // address bit 2 picks the bus half
   assign wr_data_ls1 = addr_ls1[2] ? {word_data_ls1, word_t'(0)} :
                                      {word_t'(0), word_data_ls1};
   assign wr_strb_ls1 = addr_ls1[2] ? {word_strb_ls1, word_bytes'(0)} :
                                      {word_bytes'(0), word_strb_ls1};

   // ----------------------------------------
   // ls2 registers
   // ----------------------------------------

   // a faulting access dies here
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_ls2 <= 1'b0;
         load_ls2  <= 1'b0;
         store_ls2 <= 1'b0;
      end else begin
         valid_ls2 <= ecl_lsu_valid_e & ~ale_raw_ls1;
         if (ecl_lsu_valid_e) begin
            load_ls2  <= load_ls1;
            store_ls2 <= store_ls1;
         end
      end
   end

   // payload follows the valid pulse
   always_ff @(posedge clk) begin
      if (ecl_lsu_valid_e) begin
         bus_addr_ls2 <= {addr_ls1[addr_w-1:3], off_t'(0)};
         off_ls2      <= addr_ls1[2:0];
         kind_ls2     <= kind_ls1;
         wr_data_ls2  <= wr_data_ls1;
         wr_strb_ls2  <= wr_strb_ls1;
      end
   end

   // decode must never start both holders at once
   a_ls2_one_dir: assert property (@(posedge clk) disable iff (reset)
      valid_ls2 |-> !(load_ls2 && store_ls2))
      else $error("ls2 valid with load and store both set");

endmodule

// ==== source/biu_req_hold.sv ====
`timescale 1ns/1ns

module biu_req_hold #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,

   // one cycle start from ls2
   input  logic     start,
   input  payload_t start_payload,

   // biu handshake
   input  logic     ack,
   output logic     req,
   output payload_t payload
);

   logic req_next;

   // ----------------------------------------
   // request level
   // ----------------------------------------

   // start sets it, ack drops it on the next edge
   //   start   : _-_____
   //   ack     : ____-__
   //   req     : __---__
   assign req_next = (req & ~ack) | start;

   always_ff @(posedge clk) begin
      if (reset) begin
         req <= 1'b0;
      end else begin
         req <= req_next;
      end
   end

   // payload held for the whole request
   always_ff @(posedge clk) begin
      if (reset) begin
         payload <= '0;
      end else if (start) begin
         payload <= start_payload;
      end
   end

   // ----------------------------------------
   // handshake checks
   // ----------------------------------------

   // core stalls, so only one request at a time
   a_no_restart: assert property (@(posedge clk) disable iff (reset)
      start |-> !req)
      else $error("start while request still pending");

   // biu may only answer an open request
   a_ack_in_req: assert property (@(posedge clk) disable iff (reset)
      ack |-> req)
      else $error("ack without request");

endmodule

// ==== source/lsu_load_align.sv ====
`timescale 1ns/1ns

module lsu_load_align (
   input  logic                clk,
   input  logic                reset,

   // ls2 load info, taken when the read is accepted
   input  logic                rd_ack,
   input  lsu_pkg::off_t       off_ls2,
   input  lsu_pkg::load_kind_e kind_ls2,

   // returned beat from the biu
   input  logic                biu_lsu_data_valid_ls3,
   input  lsu_pkg::bus_t       biu_lsu_data_ls3,

   // result to the core
   output logic                lsu_ecl_data_valid_ls3,
   output lsu_pkg::word_t      lsu_ecl_data_ls3
);

   import lsu_pkg::*;

   off_t       off_ls3;
   load_kind_e kind_ls3;
   word_t      word_sel_ls3;
   logic [7:0] byte_sel_ls3;
   logic [15:0] half_sel_ls3;

   // ----------------------------------------
   // ls3 capture
   // ----------------------------------------

   // ls2 may be reused once the read is accepted
   always_ff @(posedge clk) begin
      if (reset) begin
         off_ls3  <= '0;
         kind_ls3 <= lk_b;
      end else if (rd_ack) begin
         off_ls3  <= off_ls2;
         kind_ls3 <= kind_ls2;
      end
   end

   // ----------------------------------------
   // extraction
   // ----------------------------------------

   // upper word of the beat when bit 2 is set
   assign word_sel_ls3 = off_ls3[2] ? biu_lsu_data_ls3[bus_w-1:word_w] :
                                      biu_lsu_data_ls3[word_w-1:0];

   // byte at offset 1:0
   assign byte_sel_ls3 = word_sel_ls3[{off_ls3[1:0], 3'b000} +: 8];

   // half at offset bit 1, bit 0 is zero for an aligned half
   assign half_sel_ls3 = word_sel_ls3[{off_ls3[1], 4'b0000} +: 16];

   // sign or zero extend by load kind
   always_comb begin
      case (kind_ls3)
         lk_b:    lsu_ecl_data_ls3 = {{(word_w-8){byte_sel_ls3[7]}}, byte_sel_ls3};
         lk_bu:   lsu_ecl_data_ls3 = {{(word_w-8){1'b0}}, byte_sel_ls3};
         lk_h:    lsu_ecl_data_ls3 = {{(word_w-16){half_sel_ls3[15]}}, half_sel_ls3};
         lk_hu:   lsu_ecl_data_ls3 = {{(word_w-16){1'b0}}, half_sel_ls3};
         default: lsu_ecl_data_ls3 = word_sel_ls3;
      endcase
   end

   // result is valid in the same cycle as the beat
   assign lsu_ecl_data_valid_ls3 = biu_lsu_data_valid_ls3;

endmodule

// ==== source/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top (
   input  logic             clk,
   input  logic             reset,

   // ----------------------------------------
   // core side
   // ----------------------------------------
   input  logic             ecl_lsu_valid_e,
   input  lsu_pkg::lsu_op_e ecl_lsu_op_e,
   input  lsu_pkg::addr_t   ecl_lsu_base_e,
   input  lsu_pkg::addr_t   ecl_lsu_offset_e,
   input  lsu_pkg::word_t   ecl_lsu_wdata_e,

   output logic             lsu_ecl_data_valid_ls3,
   output lsu_pkg::word_t   lsu_ecl_data_ls3,
   output logic             lsu_ecl_wr_fin_ls3,
   output logic             lsu_ecl_except_ale_ls1,
   output lsu_pkg::addr_t   lsu_ecl_except_badv_ls1,

   // ----------------------------------------
   // biu side
   // ----------------------------------------
   // read channel
   output logic             lsu_biu_rd_req_ls2,
   output lsu_pkg::addr_t   lsu_biu_rd_addr_ls2,
   input  logic             biu_lsu_rd_ack_ls2,
   input  logic             biu_lsu_data_valid_ls3,
   input  lsu_pkg::bus_t    biu_lsu_data_ls3,

   // write channel
   output logic             lsu_biu_wr_req_ls2,
   output lsu_pkg::addr_t   lsu_biu_wr_addr_ls2,
   output lsu_pkg::bus_t    lsu_biu_wr_data_ls2,
   output lsu_pkg::strb_t   lsu_biu_wr_strb_ls2,
   input  logic             biu_lsu_wr_ack_ls2,
   input  logic             biu_lsu_wr_fin_ls3
);

   import lsu_pkg::*;

   logic        valid_ls2;
   logic        load_ls2;
   logic        store_ls2;
   addr_t       bus_addr_ls2;
   off_t        off_ls2;
   load_kind_e  kind_ls2;
   bus_t        wr_data_ls2;
   strb_t       wr_strb_ls2;
   wr_payload_t wr_start_payload;
   wr_payload_t wr_payload;

   // ls1 decode and ls2 registers
   lsu_ls1_stage u_ls1 (
      .clk                     (clk),
      .reset                   (reset),
      .ecl_lsu_valid_e         (ecl_lsu_valid_e),
      .ecl_lsu_op_e            (ecl_lsu_op_e),
      .ecl_lsu_base_e          (ecl_lsu_base_e),
      .ecl_lsu_offset_e        (ecl_lsu_offset_e),
      .ecl_lsu_wdata_e         (ecl_lsu_wdata_e),
      .lsu_ecl_except_ale_ls1  (lsu_ecl_except_ale_ls1),
      .lsu_ecl_except_badv_ls1 (lsu_ecl_except_badv_ls1),
      .valid_ls2               (valid_ls2),
      .load_ls2                (load_ls2),
      .store_ls2               (store_ls2),
      .bus_addr_ls2            (bus_addr_ls2),
      .off_ls2                 (off_ls2),
      .kind_ls2                (kind_ls2),
      .wr_data_ls2             (wr_data_ls2),
      .wr_strb_ls2             (wr_strb_ls2)
   );

   // read request carries only the beat address
   biu_req_hold #(.payload_t(addr_t)) u_rd_hold (
      .clk           (clk),
      .reset         (reset),
      .start         (valid_ls2 & load_ls2),
      .start_payload (bus_addr_ls2),
      .ack           (biu_lsu_rd_ack_ls2),
      .req           (lsu_biu_rd_req_ls2),
      .payload       (lsu_biu_rd_addr_ls2)
   );

   // write request packs address, data and strobe
   assign wr_start_payload = '{addr: bus_addr_ls2, data: wr_data_ls2, strb: wr_strb_ls2};

   biu_req_hold #(.payload_t(wr_payload_t)) u_wr_hold (
      .clk           (clk),
      .reset         (reset),
      .start         (valid_ls2 & store_ls2),
      .start_payload (wr_start_payload),
      .ack           (biu_lsu_wr_ack_ls2),
      .req           (lsu_biu_wr_req_ls2),
      .payload       (wr_payload)
   );

   assign lsu_biu_wr_addr_ls2 = wr_payload.addr;
   assign lsu_biu_wr_data_ls2 = wr_payload.data;
   assign lsu_biu_wr_strb_ls2 = wr_payload.strb;

   // ls3 load return
   lsu_load_align u_ls3 (
      .clk                    (clk),
      .reset                  (reset),
      .rd_ack                 (biu_lsu_rd_ack_ls2),
      .off_ls2                (off_ls2),
      .kind_ls2               (kind_ls2),
      .biu_lsu_data_valid_ls3 (biu_lsu_data_valid_ls3),
      .biu_lsu_data_ls3       (biu_lsu_data_ls3),
      .lsu_ecl_data_valid_ls3 (lsu_ecl_data_valid_ls3),
      .lsu_ecl_data_ls3       (lsu_ecl_data_ls3)
   );

   // write completion straight to the core
   assign lsu_ecl_wr_fin_ls3 = biu_lsu_wr_fin_ls3;

endmodule

// ==== test/lsu_tb_biu.sv ====
`timescale 1ns/1ns

module lsu_tb_biu (
   input  logic          clk,
   input  logic          reset,

   // request side, from the dut
   input  logic          rd_req,
   input  logic          wr_req,

   // beat returned for the next read
   input  lsu_pkg::bus_t beat,

   // handshake and return, to the dut
   output logic          rd_ack,
   output logic          wr_ack,
   output logic          data_valid,
   output lsu_pkg::bus_t data,
   output logic          wr_fin
);

   import lsu_pkg::*;

   logic [15:0] lfsr_state = 16'd66;
   logic [1:0]  delay;
   logic        is_rd;

   // fibonacci lfsr, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // ----------------------------------------
   // responder
   // ----------------------------------------

   // outputs change 1 ns after the edge
   initial begin
      rd_ack     = 1'b0;
      wr_ack     = 1'b0;
      data_valid = 1'b0;
      data       = '0;
      wr_fin     = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (!reset && (rd_req || wr_req)) begin
            is_rd = rd_req;
            // two lfsr bits give 0 to 3 wait cycles
            lfsr_state = lfsr_next(lfsr_state);
            delay[0]   = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            delay[1]   = lfsr_state[0];
            repeat (delay) begin
               @(posedge clk);
               #1;
            end
            // single cycle ack while req is still high
            if (is_rd)
               rd_ack = 1'b1;
            else
               wr_ack = 1'b1;
            @(posedge clk);
            #1;
            rd_ack = 1'b0;
            wr_ack = 1'b0;
            // return one cycle after the ack
            if (is_rd) begin
               data_valid = 1'b1;
               data       = beat;
            end else begin
               wr_fin = 1'b1;
            end
            @(posedge clk);
            #1;
            data_valid = 1'b0;
            data       = '0;
            wr_fin     = 1'b0;
         end
      end
   end

endmodule

// ==== test/lsu_tb.sv ====
`timescale 1ns/1ns

module lsu_tb;

   import lsu_pkg::*;

   // table entry holding stimulus then expected values
   typedef struct packed {
      lsu_op_e op;
      addr_t   base;
      addr_t   offset;
      word_t   wdata;
      bus_t    beat;
      logic    ale;
      addr_t   addr;
      strb_t   strb;
      bus_t    data;
      word_t   load;
   } row_t;

   // lanes 0 to 7 hold 81 72 e3 94 15 46 b7 c8
   localparam bus_t mem_beat = 64'hc8b7_4615_94e3_7281;
   localparam word_t st_word = 32'h1234_a5c6;

   logic    clk;
   logic    reset;
   logic    valid;
   lsu_op_e op;
   addr_t   base;
   addr_t   offset;
   word_t   wdata;
   bus_t    beat;
   logic    ale;
   addr_t   badv;
   logic    rd_req;
   addr_t   rd_addr;
   logic    rd_ack;
   logic    biu_valid;
   bus_t    biu_data;
   logic    load_valid;
   word_t   load_data;
   logic    wr_req;
   addr_t   wr_addr;
   bus_t    wr_data;
   strb_t   wr_strb;
   logic    wr_ack;
   logic    biu_fin;
   logic    wr_fin;

   row_t rows[$];
   int   checks = 0;
   int   errors = 0;
   int   cycles = 0;

   // previous cycle of the biu handshake
   logic  rd_req_q = 1'b0;
   logic  rd_ack_q = 1'b0;
   addr_t rd_addr_q = '0;
   logic  wr_req_q = 1'b0;
   logic  wr_ack_q = 1'b0;
   addr_t wr_addr_q = '0;
   bus_t  wr_data_q = '0;
   strb_t wr_strb_q = '0;

   // ----------------------------------------
   // clock, dut, biu model
   // ----------------------------------------

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   lsu_top uut (
      .clk                     (clk),
      .reset                   (reset),
      .ecl_lsu_valid_e         (valid),
      .ecl_lsu_op_e            (op),
      .ecl_lsu_base_e          (base),
      .ecl_lsu_offset_e        (offset),
      .ecl_lsu_wdata_e         (wdata),
      .lsu_ecl_data_valid_ls3  (load_valid),
      .lsu_ecl_data_ls3        (load_data),
      .lsu_ecl_wr_fin_ls3      (wr_fin),
      .lsu_ecl_except_ale_ls1  (ale),
      .lsu_ecl_except_badv_ls1 (badv),
      .lsu_biu_rd_req_ls2      (rd_req),
      .lsu_biu_rd_addr_ls2     (rd_addr),
      .biu_lsu_rd_ack_ls2      (rd_ack),
      .biu_lsu_data_valid_ls3  (biu_valid),
      .biu_lsu_data_ls3        (biu_data),
      .lsu_biu_wr_req_ls2      (wr_req),
      .lsu_biu_wr_addr_ls2     (wr_addr),
      .lsu_biu_wr_data_ls2     (wr_data),
      .lsu_biu_wr_strb_ls2     (wr_strb),
      .biu_lsu_wr_ack_ls2      (wr_ack),
      .biu_lsu_wr_fin_ls3      (biu_fin)
   );

   lsu_tb_biu u_biu (
      .clk        (clk),
      .reset      (reset),
      .rd_req     (rd_req),
      .wr_req     (wr_req),
      .beat       (beat),
      .rd_ack     (rd_ack),
      .wr_ack     (wr_ack),
      .data_valid (biu_valid),
      .data       (biu_data),
      .wr_fin     (biu_fin)
   );

   // ----------------------------------------
   // compare tasks
   // ----------------------------------------

   task automatic check_word(input word_t got, input word_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(input addr_t got, input addr_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bus(input bus_t got, input bus_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_strb(input strb_t got, input strb_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   // ----------------------------------------
   // stimulus table
   // ----------------------------------------

   task automatic push_row(input lsu_op_e op_i, input addr_t base_i, input addr_t offset_i,
                           input logic ale_i, input addr_t addr_i, input strb_t strb_i,
                           input bus_t data_i, input word_t load_i);
      row_t r;
      r.op     = op_i;
      r.base   = base_i;
      r.offset = offset_i;
      r.wdata  = st_word;
      r.beat   = mem_beat;
      r.ale    = ale_i;
      r.addr   = addr_i;
      r.strb   = strb_i;
      r.data   = data_i;
      r.load   = load_i;
      rows.push_back(r);
   endtask

   // loads hit beat 8000_0100 at offset off
   task automatic load_entry(input lsu_op_e op_i, input off_t off, input word_t load_i);
      push_row(op_i, 32'h8000_0100, {29'd0, off}, 1'b0, 32'h8000_0100, '0, '0, load_i);
   endtask

   // stores carry into beat 0000_4000
   task automatic store_entry(input lsu_op_e op_i, input off_t off, input strb_t strb_i,
                              input bus_t data_i);
      push_row(op_i, 32'h0000_3ffc, 32'd4 + {29'd0, off}, 1'b0, 32'h0000_4000, strb_i,
               data_i, '0);
   endtask

   // fault rows expect badv in the addr column
   task automatic fault_entry(input lsu_op_e op_i, input addr_t base_i, input addr_t offset_i,
                              input addr_t badv_i);
      push_row(op_i, base_i, offset_i, 1'b1, badv_i, '0, '0, '0);
   endtask

   task automatic fill_table();
      // signed and unsigned bytes in every lane
      load_entry(op_ld_b, 3'd0, 32'hffff_ff81);
      load_entry(op_ld_b, 3'd1, 32'h0000_0072);
      load_entry(op_ld_b, 3'd2, 32'hffff_ffe3);
      load_entry(op_ld_b, 3'd3, 32'hffff_ff94);
      load_entry(op_ld_b, 3'd4, 32'h0000_0015);
      load_entry(op_ld_b, 3'd5, 32'h0000_0046);
      load_entry(op_ld_b, 3'd6, 32'hffff_ffb7);
      load_entry(op_ld_b, 3'd7, 32'hffff_ffc8);
      load_entry(op_ld_bu, 3'd0, 32'h0000_0081);
      load_entry(op_ld_bu, 3'd1, 32'h0000_0072);
      load_entry(op_ld_bu, 3'd2, 32'h0000_00e3);
      load_entry(op_ld_bu, 3'd3, 32'h0000_0094);
      load_entry(op_ld_bu, 3'd4, 32'h0000_0015);
      load_entry(op_ld_bu, 3'd5, 32'h0000_0046);
      load_entry(op_ld_bu, 3'd6, 32'h0000_00b7);
      load_entry(op_ld_bu, 3'd7, 32'h0000_00c8);
      // halves with negative values in both bus halves
      load_entry(op_ld_h, 3'd0, 32'h0000_7281);
      load_entry(op_ld_h, 3'd2, 32'hffff_94e3);
      load_entry(op_ld_h, 3'd4, 32'h0000_4615);
      load_entry(op_ld_h, 3'd6, 32'hffff_c8b7);
      load_entry(op_ld_hu, 3'd0, 32'h0000_7281);
      load_entry(op_ld_hu, 3'd2, 32'h0000_94e3);
      load_entry(op_ld_hu, 3'd4, 32'h0000_4615);
      load_entry(op_ld_hu, 3'd6, 32'h0000_c8b7);
      load_entry(op_ld_w, 3'd0, 32'h94e3_7281);
      load_entry(op_ld_w, 3'd4, 32'hc8b7_4615);
      // store data is c6 or a5c6 or 1234a5c6
      store_entry(op_st_b, 3'd0, 8'h01, 64'h0000_0000_c6c6_c6c6);
      store_entry(op_st_b, 3'd1, 8'h02, 64'h0000_0000_c6c6_c6c6);
      store_entry(op_st_b, 3'd2, 8'h04, 64'h0000_0000_c6c6_c6c6);
      store_entry(op_st_b, 3'd3, 8'h08, 64'h0000_0000_c6c6_c6c6);
      store_entry(op_st_b, 3'd4, 8'h10, 64'hc6c6_c6c6_0000_0000);
      store_entry(op_st_b, 3'd5, 8'h20, 64'hc6c6_c6c6_0000_0000);
      store_entry(op_st_b, 3'd6, 8'h40, 64'hc6c6_c6c6_0000_0000);
      store_entry(op_st_b, 3'd7, 8'h80, 64'hc6c6_c6c6_0000_0000);
      store_entry(op_st_h, 3'd0, 8'h03, 64'h0000_0000_a5c6_a5c6);
      store_entry(op_st_h, 3'd2, 8'h0c, 64'h0000_0000_a5c6_a5c6);
      store_entry(op_st_h, 3'd4, 8'h30, 64'ha5c6_a5c6_0000_0000);
      store_entry(op_st_h, 3'd6, 8'hc0, 64'ha5c6_a5c6_0000_0000);
      store_entry(op_st_w, 3'd0, 8'h0f, 64'h0000_0000_1234_a5c6);
      store_entry(op_st_w, 3'd4, 8'hf0, 64'h1234_a5c6_0000_0000);
      // misaligned accesses with two wrapping adds
      fault_entry(op_ld_h, 32'h0000_0100, 32'hffff_ffff, 32'h0000_00ff);
      fault_entry(op_ld_hu, 32'h0000_0203, 32'h0000_0000, 32'h0000_0203);
      fault_entry(op_ld_w, 32'h0000_0300, 32'h0000_0006, 32'h0000_0306);
      fault_entry(op_st_h, 32'h0000_0401, 32'h0000_0004, 32'h0000_0405);
      fault_entry(op_st_w, 32'hffff_fffd, 32'h0000_0004, 32'h0000_0001);
   endtask

   // ----------------------------------------
   // one operation from issue to completion
   // ----------------------------------------

   task automatic run_row(input row_t r);
      logic is_store;
      logic done;
      is_store = r.op inside {op_st_b, op_st_h, op_st_w};
      done     = 1'b0;
      @(posedge clk);
      #1;
      valid  = 1'b1;
      op     = r.op;
      base   = r.base;
      offset = r.offset;
      wdata  = r.wdata;
      beat   = r.beat;
      // fault is combinational in the valid cycle
      @(negedge clk);
      check_bit(ale, r.ale, "alignment fault");
      if (r.ale)
         check_addr(badv, r.addr, "bad address");
      @(posedge clk);
      #1;
      valid  = 1'b0;
      op     = op_nop;
      // operands move away so ls2 must hold its own copy
      base   = ~r.base;
      offset = ~r.offset;
      wdata  = ~r.wdata;
      if (r.ale) begin
         repeat (4) begin
            @(negedge clk);
            check_bit(rd_req, 1'b0, "read request after fault");
            check_bit(wr_req, 1'b0, "write request after fault");
         end
      end else begin
         while (!done) begin
            @(negedge clk);
            if (is_store) begin
               check_bit(rd_req, 1'b0, "read request during store");
               if (wr_req) begin
                  check_addr(wr_addr, r.addr, "write address");
                  check_bus(wr_data, r.data, "write data");
                  check_strb(wr_strb, r.strb, "write strobe");
               end
               done = wr_fin;
            end else begin
               check_bit(wr_req, 1'b0, "write request during load");
               if (rd_req)
                  check_addr(rd_addr, r.addr, "read address");
               if (load_valid)
                  check_word(load_data, r.load, "load result");
               done = load_valid;
            end
         end
      end
   endtask

   // ----------------------------------------
   // handshake monitor
   // ----------------------------------------

   // req holds with a stable payload until ack and then drops
   always @(negedge clk) begin
      if (!reset) begin
         if (rd_req_q && !rd_ack_q) begin
            check_bit(rd_req, 1'b1, "read request dropped before ack");
            check_addr(rd_addr, rd_addr_q, "read address changed");
         end
         if (rd_ack_q)
            check_bit(rd_req, 1'b0, "read request after ack");
         if (wr_req_q && !wr_ack_q) begin
            check_bit(wr_req, 1'b1, "write request dropped before ack");
            check_addr(wr_addr, wr_addr_q, "write address changed");
            check_bus(wr_data, wr_data_q, "write data changed");
            check_strb(wr_strb, wr_strb_q, "write strobe changed");
         end
         if (wr_ack_q)
            check_bit(wr_req, 1'b0, "write request after ack");
      end
      rd_req_q  <= rd_req;
      rd_ack_q  <= rd_ack;
      rd_addr_q <= rd_addr;
      wr_req_q  <= wr_req;
      wr_ack_q  <= wr_ack;
      wr_addr_q <= wr_addr;
      wr_data_q <= wr_data;
      wr_strb_q <= wr_strb;
   end

   // 12 cycles per row plus reset margin
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= rows.size() * 12 + 20) begin
         $display("timeout: operations did not complete within %0d cycles", cycles);
         $display("Regression failed");
         $finish;
      end
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------

   initial begin
      reset  = 1'b1;
      valid  = 1'b0;
      op     = op_nop;
      base   = '0;
      offset = '0;
      wdata  = '0;
      beat   = '0;
      fill_table();
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      check_bit(rd_req, 1'b0, "read request after reset");
      check_bit(wr_req, 1'b0, "write request after reset");
      foreach (rows[i])
         run_row(rows[i]);
      $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// ==== build.f ====
source/lsu_pkg.sv
source/lsu_ls1_stage.sv
source/biu_req_hold.sv
source/lsu_load_align.sv
source/lsu_top.sv
test/lsu_tb_biu.sv
test/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the lsu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f build.f -o lsu_sim

./obj_dir/lsu_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Regression failed" sim.log; then
   exit 1
fi
